/* Bender.yml */
package:
  name: request_scheduler

sources:
  - sdram_sched_pkg.sv
  - req_fifo.sv
  - bank_timer.sv
  - bank_machine.sv
  - cmd_arbiter.sv
  - request_scheduler.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_request_scheduler.sv

/* bank_machine.sv */
// One bank's request queue and timer, proposing the next command for the head request
`default_nettype none

module bank_machine import sdram_sched_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       push,
    input  mem_req_t   req,
    input  logic       grant,
    output logic       full,
    output logic       prop_valid,
    output sdram_cmd_t prop
);

    mem_req_t            head;
    logic                empty;
    logic                open;
    logic                busy;
    logic [ROW_BITS-1:0] open_row;
    sdram_cmd_e          kind;
    logic                pop;
    logic                start_act;
    logic                start_pre;

    req_fifo #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .payload_t   (mem_req_t)
    ) u_queue (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (push),
        .pop    (pop),
        .din    (req),
        .dout   (head),
        .full   (full),
        .empty  (empty)
    );

    bank_timer #(
        .ACT_LATENCY (ACT_LATENCY),
        .PRE_LATENCY (PRE_LATENCY)
    ) u_timer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .start_act (start_act),
        .start_pre (start_pre),
        .act_row   (head.row),
        .open      (open),
        .open_row  (open_row),
        .busy      (busy)
    );

    // Classify the head request against the bank state
    always_comb begin
        if (!open) begin
            kind = CMD_ACTIVATE;
        end else if (head.row == open_row) begin
            kind = head.write ? CMD_WRITE : CMD_READ;   // Row hit
        end else begin
            kind = CMD_PRECHARGE;                        // Row miss, close first
        end
    end

    always_comb begin
        prop.kind       = kind;
        prop.bank_group = head.bank_group;
        prop.bank       = head.bank;
        prop.row        = (kind == CMD_PRECHARGE) ? open_row : head.row;
        prop.col        = head.col;
        prop.data       = (kind == CMD_WRITE) ? head.data : '0;
    end

    assign prop_valid = !empty && !busy;

    // Column commands retire the head, row commands leave it waiting
    assign pop       = grant && ((kind == CMD_READ) || (kind == CMD_WRITE));
    assign start_act = grant && (kind == CMD_ACTIVATE);
    assign start_pre = grant && (kind == CMD_PRECHARGE);

endmodule

`default_nettype wire

/* bank_timer.sv */
// Per-bank state: open flag, open row and busy down-counter after activate or precharge
`default_nettype none

module bank_timer import sdram_sched_pkg::*; #(
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                start_act,
    input  logic                start_pre,
    input  logic [ROW_BITS-1:0] act_row,
    output logic                open,
    output logic [ROW_BITS-1:0] open_row,
    output logic                busy
);

    localparam int MAX_LAT  = (ACT_LATENCY > PRE_LATENCY) ? ACT_LATENCY : PRE_LATENCY;
    localparam int CNT_BITS = $clog2(MAX_LAT + 1);

    logic [CNT_BITS-1:0] count;                 // Cycles left before the bank takes commands

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open  <= 1'b0;
            count <= '0;
        end else if (start_act) begin
            open  <= 1'b1;                      // Row is open from the grant edge
            count <= CNT_BITS'(ACT_LATENCY);
        end else if (start_pre) begin
            open  <= 1'b0;
            count <= CNT_BITS'(PRE_LATENCY);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // Row address is only looked at while the bank is open
    always_ff @(posedge clk_in) begin
        if (start_act) begin
            open_row <= act_row;
        end
    end

    assign busy = (count != '0);

    // The bank machine may only start the timer on an idle, settled bank
    a_start_legal: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (start_act || start_pre) |-> (!busy && !(start_act && start_pre))
    ) else $error("bank_timer: start while busy or both starts at once");

    // An activate blocks the bank for exactly ACT_LATENCY cycles
    a_act_window: assert property (
        @(posedge clk_in) disable iff (rst_in)
        start_act |=> busy [*ACT_LATENCY] ##1 !busy
    ) else $error("bank_timer: activate window length");

    // Same for a precharge with PRE_LATENCY
    a_pre_window: assert property (
        @(posedge clk_in) disable iff (rst_in)
        start_pre |=> busy [*PRE_LATENCY] ##1 !busy
    ) else $error("bank_timer: precharge window length");

endmodule

`default_nettype wire

/* cmd_arbiter.sv */
// Fixed-priority pick among bank proposals and the registered command output
`default_nettype none

module cmd_arbiter import sdram_sched_pkg::*; (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         cmd_ready,
    input  logic       [NUM_BANKS-1:0]   prop_valid,
    input  sdram_cmd_t [NUM_BANKS-1:0]   prop,
    output logic       [NUM_BANKS-1:0]   grant,
    output logic                         cmd_valid,
    output sdram_cmd_t                   cmd
);

    logic                     found;
    logic [BANK_IDX_BITS-1:0] pick;
    sdram_cmd_e               pick_kind;

    // Lowest command code wins, strict compare keeps the lowest bank on a tie
    always_comb begin
        found     = 1'b0;
        pick      = '0;
        pick_kind = CMD_PRECHARGE;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (prop_valid[i] && (!found || (prop[i].kind < pick_kind))) begin
                found     = 1'b1;
                pick      = BANK_IDX_BITS'(i);
                pick_kind = prop[i].kind;
            end
        end
    end

    // Grant only while the controller can take a command
    always_comb begin
        grant = '0;
        if (cmd_ready && found) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= |grant;                // Drops the cycle after no grant
        end
    end

    always_ff @(posedge clk_in) begin
        if (|grant) begin
            cmd <= prop[pick];
        end
    end

endmodule

`default_nettype wire

/* files.f */
sdram_sched_pkg.sv
req_fifo.sv
bank_timer.sv
bank_machine.sv
cmd_arbiter.sv
request_scheduler.sv
tb_clock_gen.sv
tb_request_scheduler.sv

/* req_fifo.sv */
// Circular request FIFO with a type-parameter payload and full and empty flags
`default_nettype none

module req_fifo #(
    parameter int  QUEUE_DEPTH = 4,
    parameter type payload_t   = logic
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     push,
    input  logic     pop,
    input  payload_t din,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    payload_t            mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // Pointer add with wrap at QUEUE_DEPTH, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] wrap_add(
        input logic [PTR_BITS-1:0] base,
        input logic [CNT_BITS-1:0] offs
    );
        logic [CNT_BITS:0] sum;
        sum = (CNT_BITS + 1)'(base) + (CNT_BITS + 1)'(offs);
        if (sum >= (CNT_BITS + 1)'(QUEUE_DEPTH)) begin
            sum = sum - (CNT_BITS + 1)'(QUEUE_DEPTH);
        end
        return PTR_BITS'(sum);
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign tail    = wrap_add(head, count);     // First free slot

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head  <= '0;
            count <= '0;
        end else begin
            if (do_pop) begin
                head <= wrap_add(head, CNT_BITS'(1));
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[tail] <= din;
        end
    end

    assign dout  = mem[head];
    assign full  = (count == CNT_BITS'(QUEUE_DEPTH));
    assign empty = (count == '0);

    // The sender sees full through the top level and must hold off
    a_no_push_full: assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full)
        else $error("req_fifo: push while full");

    // Pops come from a granted column command in the bank machine
    a_no_pop_empty: assert property (@(posedge clk_in) disable iff (rst_in) pop |-> !empty)
        else $error("req_fifo: pop while empty");

endmodule

`default_nettype wire

/* request_scheduler.sv */
// Top level: bank index decode, request routing, per-bank machines and command arbiter
`default_nettype none

module request_scheduler import sdram_sched_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 req_valid,
    input  mem_req_t             req,
    input  logic                 cmd_ready,
    output logic [NUM_BANKS-1:0] req_full,
    output logic                 cmd_valid,
    output sdram_cmd_t           cmd
);

    logic       [BANK_IDX_BITS-1:0] bank_idx;
    logic       [NUM_BANKS-1:0]     push;
    logic       [NUM_BANKS-1:0]     prop_valid;
    logic       [NUM_BANKS-1:0]     grant;
    sdram_cmd_t [NUM_BANKS-1:0]     prop;

    // Flat index is group * BANKS_PER_GROUP + bank
    assign bank_idx = BANK_IDX_BITS'(req.bank_group) * BANK_IDX_BITS'(BANKS_PER_GROUP)
                    + BANK_IDX_BITS'(req.bank);

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        assign push[g] = req_valid && (bank_idx == BANK_IDX_BITS'(g));   // Addressed bank only

        bank_machine #(
            .QUEUE_DEPTH (QUEUE_DEPTH),
            .ACT_LATENCY (ACT_LATENCY),
            .PRE_LATENCY (PRE_LATENCY)
        ) u_bank (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .push       (push[g]),
            .req        (req),
            .grant      (grant[g]),
            .full       (req_full[g]),
            .prop_valid (prop_valid[g]),
            .prop       (prop[g])
        );
    end

    cmd_arbiter u_arbiter (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .cmd_ready  (cmd_ready),
        .prop_valid (prop_valid),
        .prop       (prop),
        .grant      (grant),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd)
    );

endmodule

`default_nettype wire

/* sdram_sched_pkg.sv */
// SDRAM scheduler address widths, command encoding, request and command structs
`default_nettype none

package sdram_sched_pkg;

    // Address geometry
    localparam int GROUP_BITS      = 1;                   // Bank group select
    localparam int NUM_GROUPS      = 1 << GROUP_BITS;
    localparam int BANK_BITS       = 1;                   // Bank within a group
    localparam int BANKS_PER_GROUP = 1 << BANK_BITS;
    localparam int NUM_BANKS       = NUM_GROUPS * BANKS_PER_GROUP;
    localparam int BANK_IDX_BITS   = $clog2(NUM_BANKS);   // Flat bank index

    localparam int ROW_BITS  = 8;
    localparam int COL_BITS  = 4;
    localparam int DATA_BITS = 64;

    // Lower code wins arbitration, so the numbering is also the priority order
    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } sdram_cmd_e;

    // Request as it arrives from the sender
    typedef struct packed {
        logic [GROUP_BITS-1:0] bank_group;
        logic [BANK_BITS-1:0]  bank;
        logic [ROW_BITS-1:0]   row;
        logic [COL_BITS-1:0]   col;
        logic                  write;       // High for a write request
        logic [DATA_BITS-1:0]  data;        // Write data, ignored for reads
    } mem_req_t;

    // Command toward the memory controller
    typedef struct packed {
        sdram_cmd_e            kind;
        logic [GROUP_BITS-1:0] bank_group;
        logic [BANK_BITS-1:0]  bank;
        logic [ROW_BITS-1:0]   row;         // Row to open, or row being closed
        logic [COL_BITS-1:0]   col;
        logic [DATA_BITS-1:0]  data;        // Only meaningful on a write
    } sdram_cmd_t;

endpackage

`default_nettype wire

/* tb_clock_gen.sv */
// Testbench clock source and power-on reset
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_in,
    output logic rst_in
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;                          // Held from time zero
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
    end

    always #(PERIOD_NS / 2) clk_in = ~clk_in;

endmodule

`default_nettype wire

/* tb_request_scheduler.sv */
// Directed testbench for the SDRAM request scheduler with command monitor and checks
`default_nettype none

module tb_request_scheduler import sdram_sched_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int                  DEPTH      = 4;
    localparam int                  ACT_LAT    = 8;
    localparam int                  PRE_LAT    = 5;
    localparam int                  WAIT_LIMIT = 100;  // Cycles per wait loop
    localparam logic [ROW_BITS-1:0] ROW_A      = 8'h3c;
    localparam logic [ROW_BITS-1:0] ROW_B      = 8'hc3;
    localparam logic [ROW_BITS-1:0] ROW_C      = 8'h5a;

    logic                 clk_in;
    logic                 rst_in;
    logic                 req_valid;
    mem_req_t             req;
    logic                 cmd_ready;
    logic [NUM_BANKS-1:0] req_full;
    logic                 cmd_valid;
    sdram_cmd_t           cmd;

    int         cycle;
    int         check_errors;
    int         timeout_errors;
    sdram_cmd_t mon_cmd[$];                            // Every issued command
    int         mon_cyc[$];                            // Cycle it was seen in

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk (
        .clk_in (clk_in),
        .rst_in (rst_in)
    );

    request_scheduler dut (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req       (req),
        .cmd_ready (cmd_ready),
        .req_full  (req_full),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    always @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk_in) begin
        if (!rst_in && cmd_valid) begin
            mon_cmd.push_back(cmd);
            mon_cyc.push_back(cycle);
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            check_errors++;
            $display("ERROR %s: %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    // A precharge carries the row being closed and no meaningful data
    task automatic check_cmd(input string test, input int idx, input sdram_cmd_e kind,
                             input logic [GROUP_BITS-1:0] grp, input logic [BANK_BITS-1:0] bnk,
                             input logic [ROW_BITS-1:0] row, input logic [COL_BITS-1:0] col,
                             input logic [DATA_BITS-1:0] data);
        sdram_cmd_t got;
        string      tag;
        got = mon_cmd[idx];
        tag = $sformatf("command %0d", idx);
        check_value(test, {tag, " kind"}, kind, got.kind);
        check_value(test, {tag, " bank group"}, grp, got.bank_group);
        check_value(test, {tag, " bank"}, bnk, got.bank);
        check_value(test, {tag, " row"}, row, got.row);
        if (kind == CMD_READ || kind == CMD_WRITE) begin
            check_value(test, {tag, " column"}, col, got.col);
        end
        if (kind != CMD_PRECHARGE) begin
            check_value(test, {tag, " data"}, data, got.data);
        end
    endtask

    task automatic send_request(input logic [GROUP_BITS-1:0] grp, input logic [BANK_BITS-1:0] bnk,
                                input logic [ROW_BITS-1:0] row, input logic [COL_BITS-1:0] col,
                                input logic wr, input logic [DATA_BITS-1:0] data,
                                output int strobe_cyc);
        mem_req_t r;
        r.bank_group = grp;
        r.bank       = bnk;
        r.row        = row;
        r.col        = col;
        r.write      = wr;
        r.data       = data;
        @(posedge clk_in);
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clk_in);
        strobe_cyc = cycle;
        @(posedge clk_in);
        req_valid <= 1'b0;                             // Single-cycle strobe
    endtask

    task automatic wait_cmds(input string test, input int target, output bit ok);
        int n;
        n = 0;
        while (mon_cmd.size() < target && n < WAIT_LIMIT) begin
            @(posedge clk_in);
            n++;
        end
        ok = (mon_cmd.size() >= target);
        if (!ok) begin
            timeout_errors++;
            $display("%s: gave up after %0d cycles, expected %0d commands but saw %0d",
                     test, n, target, mon_cmd.size());
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_in && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (rst_in) begin
            timeout_errors++;
            $display("Reset was never released");
        end
    endtask

    task automatic idle_after_reset();
        @(negedge clk_in);
        check_value("idle_after_reset", "cmd_valid", 1'b0, cmd_valid);
        check_value("idle_after_reset", "req_full", '0, req_full);
        repeat (10) @(posedge clk_in);
        check_value("idle_after_reset", "command count", 0, mon_cmd.size());
    endtask

    task automatic read_after_activate();
        int                  s;
        int                  base;
        bit                  ok;
        logic [COL_BITS-1:0] col;
        base = mon_cmd.size();
        col  = COL_BITS'($urandom);
        send_request(1'b0, 1'b0, ROW_A, col, 1'b0, '0, s);     // Bank 0
        wait_cmds("read_after_activate", base + 2, ok);
        if (ok) begin
            check_cmd("read_after_activate", base, CMD_ACTIVATE, 1'b0, 1'b0, ROW_A, col, '0);
            check_cmd("read_after_activate", base + 1, CMD_READ, 1'b0, 1'b0, ROW_A, col, '0);
            check_value("read_after_activate", "activate delay", 2, mon_cyc[base] - s);
            check_value("read_after_activate", "read delay", ACT_LAT + 1,
                        mon_cyc[base + 1] - mon_cyc[base]);
        end
    endtask

    task automatic write_with_data();
        int                   s;
        int                   base;
        bit                   ok;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] data;
        base = mon_cmd.size();
        row  = ROW_BITS'($urandom);
        col  = COL_BITS'($urandom);
        data = {$urandom, $urandom};
        send_request(1'b1, 1'b1, row, col, 1'b1, data, s);     // Bank 3
        wait_cmds("write_with_data", base + 2, ok);
        if (ok) begin
            check_cmd("write_with_data", base, CMD_ACTIVATE, 1'b1, 1'b1, row, col, '0);
            check_cmd("write_with_data", base + 1, CMD_WRITE, 1'b1, 1'b1, row, col, data);
            check_value("write_with_data", "write delay", ACT_LAT + 1,
                        mon_cyc[base + 1] - mon_cyc[base]);
        end
    endtask

    task automatic row_miss();
        int                  s;
        int                  base;
        bit                  ok;
        logic [COL_BITS-1:0] col;
        base = mon_cmd.size();
        col  = COL_BITS'($urandom);
        send_request(1'b0, 1'b0, ROW_B, col, 1'b0, '0, s);     // Bank 0 is open on ROW_A
        wait_cmds("row_miss", base + 3, ok);
        if (ok) begin
            check_cmd("row_miss", base, CMD_PRECHARGE, 1'b0, 1'b0, ROW_A, col, '0);
            check_cmd("row_miss", base + 1, CMD_ACTIVATE, 1'b0, 1'b0, ROW_B, col, '0);
            check_cmd("row_miss", base + 2, CMD_READ, 1'b0, 1'b0, ROW_B, col, '0);
            check_value("row_miss", "precharge gap long enough", 1'b1,
                        (mon_cyc[base + 1] - mon_cyc[base]) >= PRE_LAT + 1);
        end
    endtask

    task automatic priority_order();
        int                  s;
        int                  base;
        bit                  ok;
        logic [COL_BITS-1:0] col0;
        logic [COL_BITS-1:0] col1;
        base = mon_cmd.size();
        col0 = COL_BITS'($urandom);
        col1 = COL_BITS'($urandom);
        @(posedge clk_in);
        cmd_ready <= 1'b0;
        send_request(1'b0, 1'b1, ROW_C, col1, 1'b0, '0, s);    // Bank 1 needs an activate
        send_request(1'b0, 1'b0, ROW_B, col0, 1'b0, '0, s);    // Hit in bank 0
        repeat (5) begin
            @(negedge clk_in);
            check_value("priority_order", "cmd_valid while held", 1'b0, cmd_valid);
        end
        check_value("priority_order", "commands while held", base, mon_cmd.size());
        @(posedge clk_in);
        cmd_ready <= 1'b1;
        wait_cmds("priority_order", base + 3, ok);
        if (ok) begin
            check_cmd("priority_order", base, CMD_READ, 1'b0, 1'b0, ROW_B, col0, '0);
            check_cmd("priority_order", base + 1, CMD_ACTIVATE, 1'b0, 1'b1, ROW_C, col1, '0);
            check_cmd("priority_order", base + 2, CMD_READ, 1'b0, 1'b1, ROW_C, col1, '0);
        end
    endtask

    task automatic queue_full();
        int                   s;
        int                   base;
        bit                   ok;
        logic [COL_BITS-1:0]  cols [DEPTH];
        logic                 wrs  [DEPTH];
        logic [DATA_BITS-1:0] datas [DEPTH];
        base = mon_cmd.size();
        @(posedge clk_in);
        cmd_ready <= 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            cols[i]  = COL_BITS'($urandom);
            wrs[i]   = i[0];                           // Reads and writes alternate
            datas[i] = wrs[i] ? {$urandom, $urandom} : '0;
            send_request(1'b1, 1'b0, ROW_A, cols[i], wrs[i], datas[i], s);   // Bank 2
        end
        @(negedge clk_in);
        check_value("queue_full", "req_full while held", 4'b0100, req_full);
        check_value("queue_full", "commands while held", base, mon_cmd.size());
        @(posedge clk_in);
        cmd_ready <= 1'b1;
        wait_cmds("queue_full", base + 1 + DEPTH, ok);
        if (ok) begin
            check_cmd("queue_full", base, CMD_ACTIVATE, 1'b1, 1'b0, ROW_A, cols[0], '0);
            for (int i = 0; i < DEPTH; i++) begin
                check_cmd("queue_full", base + 1 + i, wrs[i] ? CMD_WRITE : CMD_READ,
                          1'b1, 1'b0, ROW_A, cols[i], datas[i]);
            end
        end
        @(negedge clk_in);
        check_value("queue_full", "req_full after drain", '0, req_full);
    endtask

    initial begin
        void'($urandom(32'h19bfc3ba));
        req_valid      = 1'b0;
        req            = '0;
        cmd_ready      = 1'b1;
        check_errors   = 0;
        timeout_errors = 0;
        wait_reset();
        idle_after_reset();
        read_after_activate();
        write_with_data();
        row_miss();
        priority_order();
        queue_full();
        $display("Errors: %0d value mismatches, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
